//--- include/dcache_consts.svh
/* data cache hit stage constants */

`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// core word and physical address
`define DC_XLEN 32
`define DC_PLEN 32

// block geometry
`define DC_BLK_BITS 128
`define DC_WAYS 2

// address split: tag | index | block offset
`define DC_IDX_BITS 4
`define DC_BLK_OFFS_BITS 4
`define DC_DAT_OFFS_BITS 2
`define DC_TAG_BITS 24

`endif

//--- src/dcache_pkg.sv
/* data cache hit stage types */

`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

  // data and address vectors
  typedef logic [`DC_XLEN-1:0] word_t;
  typedef logic [`DC_XLEN/8-1:0] be_t;
  typedef logic [`DC_PLEN-1:0] adr_t;

  // block and its byte enables
  typedef logic [`DC_BLK_BITS-1:0] line_t;
  typedef logic [`DC_BLK_BITS/8-1:0] line_be_t;

  // address fields
  typedef logic [`DC_IDX_BITS-1:0] idx_t;
  typedef logic [`DC_TAG_BITS-1:0] tag_t;
  typedef logic [`DC_DAT_OFFS_BITS-1:0] dat_offs_t;

  // one-hot way select
  typedef logic [`DC_WAYS-1:0] ways_t;

  // command toward the bus interface
  typedef enum logic [1:0] {
    NOP,
    READWAY,
    WRITEWAY
  } biucmd_e;

  // miss controller states
  typedef enum logic [2:0] {
    ARMED,
    EVICT,
    READ,
    RECOVER0,
    RECOVER1
  } memfsm_e;

endpackage

`default_nettype wire

//--- src/dcache_hit_path.sv
/* data cache hit datapath */

`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_hit_path (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 flush_i,
  input  wire logic                 req_i,
  input  wire logic                 wreq_i,
  input  wire logic                 cache_hit_i,
  input  dcache_pkg::adr_t          adr_i,
  input  dcache_pkg::be_t           be_i,
  input  dcache_pkg::word_t         d_i,
  input  dcache_pkg::ways_t         ways_hit_i,
  input  dcache_pkg::line_t         cache_line_i,
  input  wire logic                 writebuffer_ack_i,
  output logic                      writebuffer_we_o,
  output dcache_pkg::idx_t          writebuffer_idx_o,
  output dcache_pkg::dat_offs_t     writebuffer_offs_o,
  output dcache_pkg::word_t         writebuffer_data_o,
  output dcache_pkg::line_be_t      writebuffer_be_o,
  output dcache_pkg::ways_t         writebuffer_ways_hit_o,
  output dcache_pkg::word_t         hit_word_o
);

  import dcache_pkg::*;

  idx_t      idx;
  dat_offs_t dat_offs;
  logic      write_hit;
  logic      bypass_wb;
  line_t     wb_line;
  line_t     merged_line;

  assign idx       = adr_i[`DC_BLK_OFFS_BITS +: `DC_IDX_BITS];
  assign dat_offs  = adr_i[`DC_BLK_OFFS_BITS-1 -: `DC_DAT_OFFS_BITS];
  assign write_hit = req_i & ~flush_i & wreq_i & cache_hit_i;

  ////////////////////////////////////////////////////////////
  // write buffer
  ////////////////////////////////////////////////////////////

  // full from a write hit until the memories take it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      writebuffer_we_o <= 1'b0;
    end else if (flush_i) begin
      writebuffer_we_o <= 1'b0;
    end else if (write_hit) begin
      writebuffer_we_o <= 1'b1;
    end else if (writebuffer_ack_i) begin
      writebuffer_we_o <= 1'b0;
    end
  end

  // byte enables already placed at the word's lane in the block
  always_ff @(posedge clk_i) begin
    if (write_hit) begin
      writebuffer_idx_o      <= idx;
      writebuffer_offs_o     <= dat_offs;
      writebuffer_data_o     <= d_i;
      writebuffer_be_o       <= line_be_t'(be_i) << (dat_offs * (`DC_XLEN/8));
      writebuffer_ways_hit_o <= ways_hit_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // bypass merge and word select
  ////////////////////////////////////////////////////////////

  // pending write to the block being read
  assign bypass_wb = writebuffer_we_o &
                     (idx == writebuffer_idx_o) &
                     (ways_hit_i == writebuffer_ways_hit_o);

  assign wb_line = {(`DC_BLK_BITS/`DC_XLEN){writebuffer_data_o}};

  always_comb begin
    merged_line = cache_line_i;
    for (int i = 0; i < `DC_BLK_BITS/8; i++) begin
      if (bypass_wb && writebuffer_be_o[i]) begin
        merged_line[i*8 +: 8] = wb_line[i*8 +: 8];
      end
    end
  end

  assign hit_word_o = merged_line[dat_offs*`DC_XLEN +: `DC_XLEN];

  // tag compare must never report more than one way
  a_ways_hit_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cache_hit_i |-> $onehot0(ways_hit_i)
  );

endmodule

`default_nettype wire

//--- src/dcache_miss_ctrl.sv
/* data cache miss controller */

`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_miss_ctrl (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             flush_i,
  input  wire logic             req_i,
  input  wire logic             cache_hit_i,
  input  wire logic             way_dirty_i,
  input  dcache_pkg::adr_t      adr_i,
  input  dcache_pkg::ways_t     fill_way_i,
  input  wire logic             writebuffer_we_i,
  input  dcache_pkg::idx_t      writebuffer_idx_i,
  input  dcache_pkg::ways_t     writebuffer_ways_hit_i,
  input  wire logic             biucmd_ack_i,
  input  wire logic             biucmd_busy_i,
  input  wire logic             biu_err_i,
  output dcache_pkg::biucmd_e   biucmd_o,
  output dcache_pkg::ways_t     fill_way_o,
  output logic                  filling_o,
  output logic                  armed_o,
  output logic                  evict_read_o,
  output dcache_pkg::memfsm_e   state_o,
  output dcache_pkg::idx_t      idx_o,
  output dcache_pkg::tag_t      core_tag_o
);

  import dcache_pkg::*;

  memfsm_e state;
  memfsm_e nxt_state;
  biucmd_e nxt_biucmd;
  logic    start_fill;
  logic    evict_read;
  logic    wb_conflict;

  assign idx_o      = adr_i[`DC_BLK_OFFS_BITS +: `DC_IDX_BITS];
  assign core_tag_o = adr_i[`DC_PLEN-1 -: `DC_TAG_BITS];
  assign state_o    = state;

  // victim block still has a write waiting in the buffer
  assign wb_conflict = writebuffer_we_i &
                       (idx_o == writebuffer_idx_i) &
                       (fill_way_i == writebuffer_ways_hit_i);

  assign start_fill = (state == ARMED) & req_i & ~flush_i & ~cache_hit_i & ~biucmd_busy_i;

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    nxt_state  = state;
    nxt_biucmd = NOP;
    evict_read = 1'b0;

    unique case (state)
      ARMED: begin
        if (start_fill) begin
          // new block is read first, the dirty one written after
          nxt_biucmd = READWAY;
          if (way_dirty_i || wb_conflict) begin
            nxt_state  = EVICT;
            evict_read = 1'b1;
          end else begin
            nxt_state = READ;
          end
        end
      end
      EVICT: begin
        if (biucmd_ack_i || biu_err_i) begin
          nxt_state  = RECOVER0;
          nxt_biucmd = WRITEWAY;
        end
      end
      READ: begin
        if (biucmd_ack_i || biu_err_i) begin
          nxt_state = RECOVER0;
        end
      end
      // index set up, then memories re-read
      RECOVER0: nxt_state = RECOVER1;
      RECOVER1: nxt_state = ARMED;
      default:  nxt_state = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state        <= ARMED;
      biucmd_o     <= NOP;
      armed_o      <= 1'b1;
      filling_o    <= 1'b0;
      evict_read_o <= 1'b0;
    end else begin
      state        <= nxt_state;
      biucmd_o     <= nxt_biucmd;
      armed_o      <= (nxt_state == ARMED);
      filling_o    <= (nxt_state == EVICT) || (nxt_state == READ);
      evict_read_o <= evict_read;
    end
  end

  // refill goes to the way picked at the miss
  always_ff @(posedge clk_i) begin
    if (start_fill) begin
      fill_way_o <= fill_way_i;
    end
  end

  a_no_double_readway : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (biucmd_o == READWAY) |=> (biucmd_o != READWAY)
  );

endmodule

`default_nettype wire

//--- src/dcache_resp.sv
/* data cache core response */

`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_resp (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             flush_i,
  input  wire logic             req_i,
  input  wire logic             cache_hit_i,
  input  dcache_pkg::memfsm_e   state_i,
  input  dcache_pkg::adr_t      adr_i,
  input  dcache_pkg::word_t     hit_word_i,
  input  dcache_pkg::word_t     biu_q_i,
  input  wire logic             biu_ack_i,
  input  wire logic             biu_err_i,
  input  dcache_pkg::adr_t      biu_adro_i,
  output logic                  stall_o,
  output logic                  latchmem_o,
  output logic                  ack_o,
  output dcache_pkg::word_t     q_o,
  output logic                  err_o
);

  import dcache_pkg::*;

  localparam int unsigned WORD_LSB = $clog2(`DC_XLEN/8);

  logic  valid_req;
  logic  cache_ack;
  logic  biu_word_ack;
  word_t rd_word;

  assign valid_req = req_i & ~flush_i;
  assign cache_ack = valid_req & cache_hit_i;

  // bus returns the word the core is waiting for
  assign biu_word_ack = valid_req & biu_ack_i &
                        (biu_adro_i[`DC_PLEN-1:WORD_LSB] == adr_i[`DC_PLEN-1:WORD_LSB]);

  ////////////////////////////////////////////////////////////
  // stall and memory latch
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (state_i)
      ARMED: begin
        stall_o    = valid_req & ~cache_hit_i;
        latchmem_o = ~stall_o;
      end
      EVICT, READ: begin
        stall_o    = ~(biu_word_ack | cache_ack);
        latchmem_o = ~stall_o;
      end
      RECOVER0: begin
        stall_o    = 1'b1;
        latchmem_o = 1'b0;
      end
      default: begin
        // RECOVER1 latches the re-read memories
        stall_o    = 1'b1;
        latchmem_o = 1'b1;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // core response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      unique case (state_i)
        ARMED:       ack_o <= cache_ack;
        EVICT, READ: ack_o <= cache_ack | biu_word_ack;
        default:     ack_o <= 1'b0;
      endcase
      err_o <= biu_err_i;
    end
  end

  assign rd_word = cache_hit_i ? hit_word_i : biu_q_i;

  always_ff @(posedge clk_i) begin
    q_o <= rd_word;
  end

endmodule

`default_nettype wire

//--- src/dcache_hit_stage.sv
/* data cache hit stage */

`timescale 1ns/10ps
`default_nettype none

module dcache_hit_stage (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,

  // core side
  input  wire logic             flush_i,
  input  wire logic             req_i,
  input  wire logic             wreq_i,
  input  dcache_pkg::adr_t      adr_i,
  input  dcache_pkg::be_t       be_i,
  input  dcache_pkg::word_t     d_i,
  output logic                  stall_o,
  output logic                  ack_o,
  output dcache_pkg::word_t     q_o,
  output logic                  err_o,

  // cache memories
  input  wire logic             cache_hit_i,
  input  dcache_pkg::ways_t     ways_hit_i,
  input  dcache_pkg::line_t     cache_line_i,
  input  wire logic             way_dirty_i,
  input  dcache_pkg::ways_t     fill_way_i,
  output dcache_pkg::idx_t      idx_o,
  output dcache_pkg::tag_t      core_tag_o,
  output logic                  latchmem_o,
  output logic                  armed_o,
  output logic                  filling_o,
  output dcache_pkg::ways_t     fill_way_o,
  output logic                  evict_read_o,

  // write buffer
  input  wire logic             writebuffer_ack_i,
  output logic                  writebuffer_we_o,
  output dcache_pkg::idx_t      writebuffer_idx_o,
  output dcache_pkg::dat_offs_t writebuffer_offs_o,
  output dcache_pkg::word_t     writebuffer_data_o,
  output dcache_pkg::line_be_t  writebuffer_be_o,
  output dcache_pkg::ways_t     writebuffer_ways_hit_o,

  // bus interface
  output dcache_pkg::biucmd_e   biucmd_o,
  input  wire logic             biucmd_ack_i,
  input  wire logic             biucmd_busy_i,
  input  dcache_pkg::word_t     biu_q_i,
  input  wire logic             biu_ack_i,
  input  wire logic             biu_err_i,
  input  dcache_pkg::adr_t      biu_adro_i
);

  import dcache_pkg::*;

  memfsm_e state;
  word_t   hit_word;

  dcache_hit_path u_hit_path (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .flush_i                (flush_i),
    .req_i                  (req_i),
    .wreq_i                 (wreq_i),
    .cache_hit_i            (cache_hit_i),
    .adr_i                  (adr_i),
    .be_i                   (be_i),
    .d_i                    (d_i),
    .ways_hit_i             (ways_hit_i),
    .cache_line_i           (cache_line_i),
    .writebuffer_ack_i      (writebuffer_ack_i),
    .writebuffer_we_o       (writebuffer_we_o),
    .writebuffer_idx_o      (writebuffer_idx_o),
    .writebuffer_offs_o     (writebuffer_offs_o),
    .writebuffer_data_o     (writebuffer_data_o),
    .writebuffer_be_o       (writebuffer_be_o),
    .writebuffer_ways_hit_o (writebuffer_ways_hit_o),
    .hit_word_o             (hit_word)
  );

  // write buffer state fed back for the eviction decision
  dcache_miss_ctrl u_miss_ctrl (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .flush_i                (flush_i),
    .req_i                  (req_i),
    .cache_hit_i            (cache_hit_i),
    .way_dirty_i            (way_dirty_i),
    .adr_i                  (adr_i),
    .fill_way_i             (fill_way_i),
    .writebuffer_we_i       (writebuffer_we_o),
    .writebuffer_idx_i      (writebuffer_idx_o),
    .writebuffer_ways_hit_i (writebuffer_ways_hit_o),
    .biucmd_ack_i           (biucmd_ack_i),
    .biucmd_busy_i          (biucmd_busy_i),
    .biu_err_i              (biu_err_i),
    .biucmd_o               (biucmd_o),
    .fill_way_o             (fill_way_o),
    .filling_o              (filling_o),
    .armed_o                (armed_o),
    .evict_read_o           (evict_read_o),
    .state_o                (state),
    .idx_o                  (idx_o),
    .core_tag_o             (core_tag_o)
  );

  dcache_resp u_resp (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .req_i       (req_i),
    .cache_hit_i (cache_hit_i),
    .state_i     (state),
    .adr_i       (adr_i),
    .hit_word_i  (hit_word),
    .biu_q_i     (biu_q_i),
    .biu_ack_i   (biu_ack_i),
    .biu_err_i   (biu_err_i),
    .biu_adro_i  (biu_adro_i),
    .stall_o     (stall_o),
    .latchmem_o  (latchmem_o),
    .ack_o       (ack_o),
    .q_o         (q_o),
    .err_o       (err_o)
  );

endmodule

`default_nettype wire

//--- verif/dcache_checker.sv
/* data cache hit stage checker */

`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_checker (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             flush_i,
  input  wire logic             req_i,
  input  wire logic             wreq_i,
  input  dcache_pkg::adr_t      adr_i,
  input  dcache_pkg::be_t       be_i,
  input  dcache_pkg::word_t     d_i,
  input  wire logic             cache_hit_i,
  input  dcache_pkg::ways_t     ways_hit_i,
  input  dcache_pkg::line_t     cache_line_i,
  input  wire logic             way_dirty_i,
  input  dcache_pkg::ways_t     fill_way_i,
  input  wire logic             writebuffer_ack_i,
  input  wire logic             biucmd_ack_i,
  input  wire logic             biucmd_busy_i,
  input  wire logic             biu_ack_i,
  input  wire logic             biu_err_i,
  input  dcache_pkg::word_t     biu_q_i,
  input  dcache_pkg::adr_t      biu_adro_i,
  input  wire logic             stall_o,
  input  wire logic             latchmem_o,
  input  wire logic             ack_o,
  input  dcache_pkg::word_t     q_o,
  input  wire logic             err_o,
  input  dcache_pkg::idx_t      idx_o,
  input  dcache_pkg::tag_t      core_tag_o,
  input  wire logic             armed_o,
  input  wire logic             filling_o,
  input  dcache_pkg::ways_t     fill_way_o,
  input  wire logic             evict_read_o,
  input  dcache_pkg::biucmd_e   biucmd_o,
  input  wire logic             writebuffer_we_o,
  input  dcache_pkg::idx_t      writebuffer_idx_o,
  input  dcache_pkg::dat_offs_t writebuffer_offs_o,
  input  dcache_pkg::word_t     writebuffer_data_o,
  input  dcache_pkg::line_be_t  writebuffer_be_o,
  input  dcache_pkg::ways_t     writebuffer_ways_hit_o
);

  import dcache_pkg::*;

  int err_cnt = 0;
  int test_err = 0;
  int test_cnt = 0;
  int pass_cnt = 0;
  int readway_cnt = 0;
  int writeway_cnt = 0;
  int evict_cnt = 0;

  logic      check_en;
  logic      valid;
  logic      bus_word;
  logic      exp_ack;
  word_t     exp_q;
  logic      exp_err;
  logic      bus_now;
  logic      exp_stall;
  logic      exp_latch;

  // expected write buffer contents
  logic      m_we;
  idx_t      m_idx;
  dat_offs_t m_offs;
  word_t     m_data;
  line_be_t  m_be;
  ways_t     m_ways;

  // expected miss controller phase, m_rec counts the recovery cycles left
  logic      m_armed;
  logic      m_filling;
  logic      m_evict;
  int        m_rec;
  biucmd_e   m_cmd;
  logic      m_evict_rd;
  logic      m_fill_seen;
  ways_t     m_fill_way;

  // addressed word, with pending buffer bytes on the same index and ways
  function automatic word_t ref_word(input line_t line, input adr_t adr, input ways_t ways);
    word_t w;
    int    lane;
    logic  merge;
    merge = m_we && (adr[7:4] == m_idx) && (ways == m_ways);
    for (int b = 0; b < 4; b++) begin
      lane = adr[3:2] * 4 + b;
      if (merge && m_be[lane]) begin
        w[b*8 +: 8] = m_data[b*8 +: 8];
      end else begin
        w[b*8 +: 8] = line[lane*8 +: 8];
      end
    end
    return w;
  endfunction

  task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    err_cnt++;
    test_err++;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (test_err == 0) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_err);
    end
    test_err = 0;
  endtask

  task automatic print_summary();
    $display("%0d tests run, %0d ok, %0d errors", test_cnt, pass_cnt, err_cnt);
  endtask

  ////////////////////////////////////////////////////////////
  // expectations from the sampled inputs
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      check_en    = 1'b0;
      exp_ack     = 1'b0;
      exp_err     = 1'b0;
      m_we        = 1'b0;
      m_armed     = 1'b1;
      m_filling   = 1'b0;
      m_evict     = 1'b0;
      m_rec       = 0;
      m_cmd       = NOP;
      m_evict_rd  = 1'b0;
      m_fill_seen = 1'b0;
    end else begin
      valid    = req_i & ~flush_i;
      bus_word = m_filling & valid & biu_ack_i & (biu_adro_i[31:2] == adr_i[31:2]);
      exp_ack  = ((m_armed | m_filling) & valid & cache_hit_i) | bus_word;
      exp_q    = cache_hit_i ? ref_word(cache_line_i, adr_i, ways_hit_i) : biu_q_i;
      exp_err  = biu_err_i;

      // miss sequence
      m_cmd      = NOP;
      m_evict_rd = 1'b0;
      if (m_armed) begin
        if (valid && !cache_hit_i && !biucmd_busy_i) begin
          m_armed     = 1'b0;
          m_filling   = 1'b1;
          m_cmd       = READWAY;
          m_evict     = way_dirty_i ||
                        (m_we && (adr_i[7:4] == m_idx) && (fill_way_i == m_ways));
          m_evict_rd  = m_evict;
          m_fill_way  = fill_way_i;
          m_fill_seen = 1'b1;
        end
      end else if (m_filling) begin
        if (biucmd_ack_i || biu_err_i) begin
          m_filling = 1'b0;
          m_rec     = 2;
          if (m_evict) begin
            m_cmd = WRITEWAY;
          end
        end
      end else begin
        m_rec = m_rec - 1;
        if (m_rec == 0) begin
          m_armed = 1'b1;
        end
      end

      if (flush_i) begin
        m_we = 1'b0;
      end else if (valid && wreq_i && cache_hit_i) begin
        m_we   = 1'b1;
        m_idx  = adr_i[7:4];
        m_offs = adr_i[3:2];
        m_data = d_i;
        m_be   = line_be_t'(be_i) << (adr_i[3:2] * 4);
        m_ways = ways_hit_i;
      end else if (writebuffer_ack_i) begin
        m_we = 1'b0;
      end
      if (biucmd_o == READWAY) readway_cnt++;
      if (biucmd_o == WRITEWAY) writeway_cnt++;
      if (evict_read_o) evict_cnt++;
      check_en = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // comparisons mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (check_en && rst_ni) begin
      compare("ack_o", ack_o, exp_ack);
      if (exp_ack) compare("q_o", q_o, exp_q);
      compare("err_o", err_o, exp_err);
      compare("writebuffer_we_o", writebuffer_we_o, m_we);
      if (m_we) begin
        compare("writebuffer_idx_o", writebuffer_idx_o, m_idx);
        compare("writebuffer_offs_o", writebuffer_offs_o, m_offs);
        compare("writebuffer_data_o", writebuffer_data_o, m_data);
        compare("writebuffer_be_o", writebuffer_be_o, m_be);
        compare("writebuffer_ways_hit_o", writebuffer_ways_hit_o, m_ways);
      end

      compare("armed_o", armed_o, m_armed);
      compare("filling_o", filling_o, m_filling);
      compare("biucmd_o", biucmd_o, m_cmd);
      compare("evict_read_o", evict_read_o, m_evict_rd);
      if (m_fill_seen) compare("fill_way_o", fill_way_o, m_fill_way);
      compare("idx_o", idx_o, adr_i[7:4]);
      compare("core_tag_o", core_tag_o, adr_i[31:8]);

      // armed answers a hit at once, a refill only a hit or the bus word
      bus_now = m_filling & req_i & ~flush_i & biu_ack_i &
                (biu_adro_i[31:2] == adr_i[31:2]);
      if (m_armed) begin
        exp_stall = req_i & ~flush_i & ~cache_hit_i;
      end else if (m_filling) begin
        exp_stall = ~(bus_now | (req_i & ~flush_i & cache_hit_i));
      end else begin
        exp_stall = 1'b1;
      end
      if (m_armed || m_filling) begin
        exp_latch = ~exp_stall;
      end else begin
        // second recovery cycle latches the re-read memories
        exp_latch = (m_rec == 1);
      end
      compare("stall_o", stall_o, exp_stall);
      compare("latchmem_o", latchmem_o, exp_latch);
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_dcache_hit_stage.sv
/* data cache hit stage testbench */

`timescale 1ns/10ps
`default_nettype none

`include "dcache_consts.svh"

module tb_dcache_hit_stage;

  import dcache_pkg::*;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic flush_i, req_i, wreq_i, cache_hit_i, way_dirty_i, writebuffer_ack_i;
  logic biucmd_ack_i, biucmd_busy_i, biu_ack_i, biu_err_i;
  adr_t  adr_i, biu_adro_i;
  be_t   be_i;
  word_t d_i, biu_q_i;
  ways_t ways_hit_i, fill_way_i;
  line_t cache_line_i;

  logic stall_o, ack_o, err_o, latchmem_o, armed_o, filling_o, evict_read_o;
  logic writebuffer_we_o;
  word_t q_o, writebuffer_data_o;
  idx_t idx_o, writebuffer_idx_o;
  tag_t core_tag_o;
  ways_t fill_way_o, writebuffer_ways_hit_o;
  dat_offs_t writebuffer_offs_o;
  line_be_t writebuffer_be_o;
  biucmd_e biucmd_o;

  logic [31:0] lfsr_q = 32'h8077b0a9;
  line_t       lines [16];
  adr_t        a;
  logic [31:0] r;
  int          rd0, wr0, ev0;

  always #10 clk_i = ~clk_i;

  // cache memory model, indexed by the request address
  assign cache_line_i = lines[adr_i[`DC_BLK_OFFS_BITS +: `DC_IDX_BITS]];

  dcache_hit_stage UUT (.*);

  dcache_checker u_checker (.*);

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic drive_idle();
    @(posedge clk_i);
    req_i <= 1'b0;
    wreq_i <= 1'b0;
    cache_hit_i <= 1'b0;
    biu_ack_i <= 1'b0;
    biu_err_i <= 1'b0;
  endtask

  // 0 ack_o, 1 filling_o, 2 armed_o
  task automatic wait_signal(input int which, input string what);
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < 40 && !seen; i++) begin
      @(negedge clk_i);
      case (which)
        0: seen = ack_o;
        1: seen = filling_o;
        default: seen = armed_o;
      endcase
    end
    if (!seen) u_checker.report_failure({"timeout waiting for ", what});
  endtask

  task automatic drive_access(input logic wr, input logic hit, input adr_t adr);
    take_bits(32, r);
    @(posedge clk_i);
    req_i <= 1'b1;
    wreq_i <= wr;
    cache_hit_i <= hit;
    ways_hit_i <= hit ? 2'b01 : 2'b00;
    adr_i <= adr;
    d_i <= r;
    be_i <= r[7:4] | 4'b0001;
  endtask

  // miss with a bus that answers after a random delay
  task automatic run_miss(input logic dirty, input int exp_wr, input string name);
    rd0 = u_checker.readway_cnt;
    wr0 = u_checker.writeway_cnt;
    ev0 = u_checker.evict_cnt;
    take_bits(32, a);
    take_bits(1, r);
    @(posedge clk_i);
    way_dirty_i <= dirty;
    fill_way_i <= r[0] ? 2'b10 : 2'b01;
    drive_access(1'b0, 1'b0, a);
    drive_idle();
    wait_signal(1, "filling_o");
    take_bits(2, r);
    for (int i = 0; i <= r; i++) begin
      @(negedge clk_i);
      u_checker.compare("filling_o", filling_o, 1'b1);
      u_checker.compare("stall_o", stall_o, 1'b1);
    end
    @(posedge clk_i);
    biucmd_ack_i <= 1'b1;
    @(posedge clk_i);
    biucmd_ack_i <= 1'b0;
    wait_signal(2, "armed_o");
    u_checker.compare("readway count", u_checker.readway_cnt - rd0, 1);
    u_checker.compare("writeway count", u_checker.writeway_cnt - wr0, exp_wr);
    u_checker.compare("evict_read count", u_checker.evict_cnt - ev0, exp_wr);
    u_checker.end_test(name);
  endtask

  initial begin
    {flush_i, req_i, wreq_i, cache_hit_i, way_dirty_i, writebuffer_ack_i} = '0;
    {biucmd_ack_i, biucmd_busy_i, biu_ack_i, biu_err_i} = '0;
    adr_i = '0;
    biu_adro_i = '0;
    be_i = '0;
    d_i = '0;
    biu_q_i = '0;
    ways_hit_i = '0;
    fill_way_i = 2'b01;
    for (int i = 0; i < 16; i++) begin
      for (int w = 0; w < 4; w++) begin
        take_bits(32, r);
        lines[i][w*32 +: 32] = r ^ {i[3:0], w[1:0], 26'h0};
      end
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    take_bits(32, a);
    drive_access(1'b0, 1'b1, a);
    drive_idle();
    wait_signal(0, "ack_o");
    u_checker.end_test("read hit");

    take_bits(32, a);
    drive_access(1'b1, 1'b1, a);
    drive_idle();
    repeat (3) @(posedge clk_i);
    writebuffer_ack_i <= 1'b1;
    @(posedge clk_i);
    writebuffer_ack_i <= 1'b0;
    u_checker.end_test("write hit");

    take_bits(32, a);
    drive_access(1'b1, 1'b1, a);
    drive_access(1'b0, 1'b1, a);
    drive_idle();
    wait_signal(0, "ack_o");
    @(posedge clk_i);
    writebuffer_ack_i <= 1'b1;
    @(posedge clk_i);
    writebuffer_ack_i <= 1'b0;
    u_checker.end_test("bypass");

    run_miss(1'b0, 0, "clean miss");
    run_miss(1'b1, 1, "dirty miss");

    // word returned by the bus while the refill runs
    take_bits(32, a);
    @(posedge clk_i);
    way_dirty_i <= 1'b0;
    drive_access(1'b0, 1'b0, a);
    take_bits(32, r);
    @(posedge clk_i);
    biu_ack_i <= 1'b1;
    biu_adro_i <= a;
    biu_q_i <= r;
    drive_idle();
    biu_err_i <= 1'b1;
    drive_idle();
    wait_signal(2, "armed_o");
    u_checker.end_test("bus word");

    repeat (2) @(posedge clk_i);
    u_checker.print_summary();
    if (u_checker.err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache_hit_stage.f
+incdir+include
src/dcache_pkg.sv
src/dcache_hit_path.sv
src/dcache_miss_ctrl.sv
src/dcache_resp.sv
src/dcache_hit_stage.sv
verif/dcache_checker.sv
verif/tb_dcache_hit_stage.sv

//--- Bender.yml
package:
  name: dcache_hit_stage

export_include_dirs:
  - include

sources:
  - src/dcache_pkg.sv
  - src/dcache_hit_path.sv
  - src/dcache_miss_ctrl.sv
  - src/dcache_resp.sv
  - src/dcache_hit_stage.sv
  - target: test
    files:
      - verif/dcache_checker.sv
      - verif/tb_dcache_hit_stage.sv
